// File: src/mixer_types_pkg.sv
`default_nettype none

package mixer_types_pkg;

    // eight lanes, the rotation offsets of every pass assume this.
    localparam int LANE_COUNT = 8;
    localparam int LANE_WIDTH = 32;

    typedef logic [LANE_WIDTH-1:0] lane_t;

    // lane 0 sits in the low word.
    typedef lane_t [LANE_COUNT-1:0] state_t;

    // neighbour index, modulo the lane count.
    function automatic int wrap_lane(int idx);
        return (idx + LANE_COUNT) % LANE_COUNT;
    endfunction

endpackage

`default_nettype wire

// File: src/mixer_const_pkg.sv
`default_nettype none

package mixer_const_pkg;

    localparam int unsigned XOR_SHIFT = 16;  // left shift in the xor pass.
    localparam int unsigned SUB_SHIFT = 17;  // right shift of the subtracted term.
    localparam int unsigned ADD_SHIFT = 12;  // right shift of the added term.

    // first finalize pass, primes for the multipliers.
    localparam mixer_types_pkg::lane_t FIN_MUL_A [mixer_types_pkg::LANE_COUNT] = '{
        32'd2,  32'd3,  32'd5,  32'd7,
        32'd11, 32'd13, 32'd17, 32'd19
    };

    localparam mixer_types_pkg::lane_t FIN_ADD_A [mixer_types_pkg::LANE_COUNT] = '{
        32'd3,  32'd5,  32'd7,  32'd11,
        32'd13, 32'd17, 32'd19, 32'd23
    };

    // second finalize pass.
    localparam mixer_types_pkg::lane_t FIN_MUL_B [mixer_types_pkg::LANE_COUNT] = '{
        32'd2, 32'd3,  32'd3,  32'd3,
        32'd5, 32'd13, 32'd35, 32'd87
    };

    // cubes of the lane index.
    localparam mixer_types_pkg::lane_t FIN_ADD_B [mixer_types_pkg::LANE_COUNT] = '{
        32'd0,  32'd1,   32'd8,   32'd27,
        32'd64, 32'd125, 32'd216, 32'd343
    };

endpackage

`default_nettype wire

// File: src/lane_state.sv
`timescale 1ns/1ps
`default_nettype none

module lane_state (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    seed_load,
    input  wire mixer_types_pkg::lane_t  seed_value,
    input  wire logic                    step,
    input  wire mixer_types_pkg::state_t next_state,
    output mixer_types_pkg::state_t      state
);
    import mixer_types_pkg::*;

    // lane i gets base + i.
    function automatic state_t seed_pattern(lane_t base);
        state_t pattern;

        for (int i = 0; i < LANE_COUNT; i++) begin
            pattern[i] = base + lane_t'(i);
        end
        return pattern;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= seed_pattern('0);  // index pattern.
        end else if (seed_load) begin
            state <= seed_pattern(seed_value);  // reload beats step.
        end else if (step) begin
            state <= next_state;
        end
    end

endmodule

`default_nettype wire

// File: src/mix_prelude.sv
`timescale 1ns/1ps
`default_nettype none

module mix_prelude (
    input  wire mixer_types_pkg::state_t state_in,
    output mixer_types_pkg::state_t      state_out
);
    import mixer_types_pkg::*;

    always_comb begin : prelude_passes
        state_t s;

        s = state_in;

        // offset pass.
        for (int i = 0; i < LANE_COUNT; i++) begin
            s[i] = s[i] + lane_t'(i);
        end

        // forward chain, lane 0 takes lane 7 before lane 7 moves.
        for (int i = 0; i < LANE_COUNT; i++) begin
            s[i] = s[i] + s[wrap_lane(i - 1)];
        end

        state_out = s;
    end

endmodule

`default_nettype wire

// File: src/mix_round.sv
`timescale 1ns/1ps
`default_nettype none

module mix_round (
    input  wire mixer_types_pkg::state_t state_in,
    output mixer_types_pkg::state_t      state_out
);
    import mixer_types_pkg::*;
    import mixer_const_pkg::*;

    // every pass walks lanes 0..7 in place.
    always_comb begin : round_passes
        state_t s;

        s = state_in;

        // add-subtract pass.
        for (int i = 0; i < LANE_COUNT; i++) begin
            s[i] = s[i] + s[wrap_lane(i + 1)] - s[wrap_lane(i + 5)];
        end

        // xor pass.
        for (int i = 0; i < LANE_COUNT; i++) begin
            s[i] = s[i] ^ (s[wrap_lane(i + 3)] << XOR_SHIFT);  // low half shifted up.
        end

        // shift-subtract pass.
        for (int i = 0; i < LANE_COUNT; i++) begin
            s[i] = s[i]
                 - (s[wrap_lane(i + 2)] >> SUB_SHIFT)
                 + (s[wrap_lane(i + 4)] >> ADD_SHIFT);  // logical shifts.
        end

        state_out = s;
    end

endmodule

`default_nettype wire

// File: src/cascade_round.sv
`timescale 1ns/1ps
`default_nettype none

module cascade_round (
    input  wire mixer_types_pkg::state_t state_in,
    output mixer_types_pkg::state_t      state_out
);
    import mixer_types_pkg::*;

    always_comb begin : cascade_pass
        state_t s;

        s = state_in;

        // lanes 0 and 1 still see the old tail.
        for (int i = 0; i < LANE_COUNT; i++) begin
            s[i] = s[i] + s[wrap_lane(i - 1)] - s[wrap_lane(i - 2)];
        end

        state_out = s;
    end

endmodule

`default_nettype wire

// File: src/mix_finalize.sv
`timescale 1ns/1ps
`default_nettype none

module mix_finalize (
    input  wire mixer_types_pkg::state_t state_in,
    output mixer_types_pkg::state_t      state_out
);
    import mixer_types_pkg::*;
    import mixer_const_pkg::*;

    always_comb begin : finalize_passes
        state_t s;

        s = state_in;

        // products wrap to the lane width.
        for (int i = 0; i < LANE_COUNT; i++) begin
            s[i] = s[i] * FIN_MUL_A[i] + FIN_ADD_A[i];
        end

        for (int i = 0; i < LANE_COUNT; i++) begin
            s[i] = s[i] * FIN_MUL_B[i] + FIN_ADD_B[i];
        end

        state_out = s;
    end

endmodule

`default_nettype wire

// File: src/state_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module state_mixer #(
    parameter int unsigned MIX_ROUNDS     = 2,
    parameter int unsigned CASCADE_ROUNDS = 4
) (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   step,
    input  wire logic                   seed_load,
    input  wire mixer_types_pkg::lane_t seed_value,
    output mixer_types_pkg::state_t     state
);
    import mixer_types_pkg::*;

    state_t prelude_out;
    state_t mix_stage  [MIX_ROUNDS];
    state_t casc_stage [CASCADE_ROUNDS];
    state_t next_state;  // full update, one step ahead.

    lane_state u_lane_state (
        .clk        (clk),
        .reset      (reset),
        .seed_load  (seed_load),
        .seed_value (seed_value),
        .step       (step),
        .next_state (next_state),
        .state      (state)
    );

    mix_prelude u_prelude (
        .state_in  (state),
        .state_out (prelude_out)
    );

    for (genvar k = 0; k < MIX_ROUNDS; k++) begin : g_mix
        if (k == 0) begin : g_first
            mix_round u_round (
                .state_in  (prelude_out),
                .state_out (mix_stage[k])
            );
        end else begin : g_next
            mix_round u_round (
                .state_in  (mix_stage[k-1]),
                .state_out (mix_stage[k])
            );
        end
    end

    // cascades start from the last mix round.
    for (genvar k = 0; k < CASCADE_ROUNDS; k++) begin : g_casc
        if (k == 0) begin : g_first
            cascade_round u_round (
                .state_in  (mix_stage[MIX_ROUNDS-1]),
                .state_out (casc_stage[k])
            );
        end else begin : g_next
            cascade_round u_round (
                .state_in  (casc_stage[k-1]),
                .state_out (casc_stage[k])
            );
        end
    end

    mix_finalize u_finalize (
        .state_in  (casc_stage[CASCADE_ROUNDS-1]),
        .state_out (next_state)
    );

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter real PERIOD_NS    = 8.0,
    parameter int  RESET_CYCLES = 4
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;  // released mid-cycle after the last reset edge.
    end

endmodule

`default_nettype wire

// File: tb/tb_mixer_model.svh
`ifndef TB_MIXER_MODEL_SVH
`define TB_MIXER_MODEL_SVH

// maximal 32-bit Galois LFSR, taps 32 22 2 1.
function automatic logic [31:0] lfsr_next(logic [31:0] value);
    logic [31:0] shifted;

    shifted = value >> 1;
    if (value[0]) begin
        shifted = shifted ^ 32'h8020_0003;
    end
    return shifted;
endfunction

// lane i starts at base + i.
function automatic state_t model_seed(lane_t base);
    state_t s;

    for (int i = 0; i < LANE_COUNT; i++) begin
        s[i] = base + lane_t'(i);
    end
    return s;
endfunction

// neighbour lane, wraps over eight lanes.
function automatic int lane_of(int i, int offset);
    return (i + offset) & (LANE_COUNT - 1);
endfunction

// one full update, every pass walks lanes 0 to 7 in place.
function automatic state_t model_update(state_t start, int mix_rounds, int cascade_rounds);
    state_t s;

    s = start;
    for (int i = 0; i < LANE_COUNT; i++) begin
        s[i] = s[i] + lane_t'(i);
    end
    for (int i = 0; i < LANE_COUNT; i++) begin
        s[i] = s[i] + s[lane_of(i, -1)];
    end
    for (int r = 0; r < mix_rounds; r++) begin
        for (int i = 0; i < LANE_COUNT; i++) begin
            s[i] = s[i] + s[lane_of(i, 1)] - s[lane_of(i, 5)];
        end
        for (int i = 0; i < LANE_COUNT; i++) begin
            s[i] = s[i] ^ (s[lane_of(i, 3)] << XOR_SHIFT);
        end
        for (int i = 0; i < LANE_COUNT; i++) begin
            s[i] = s[i] - (s[lane_of(i, 2)] >> SUB_SHIFT) + (s[lane_of(i, 4)] >> ADD_SHIFT);
        end
    end
    for (int r = 0; r < cascade_rounds; r++) begin
        for (int i = 0; i < LANE_COUNT; i++) begin
            s[i] = s[i] + s[lane_of(i, -1)] - s[lane_of(i, -2)];
        end
    end
    for (int i = 0; i < LANE_COUNT; i++) begin
        s[i] = s[i] * FIN_MUL_A[i] + FIN_ADD_A[i];
    end
    for (int i = 0; i < LANE_COUNT; i++) begin
        s[i] = s[i] * FIN_MUL_B[i] + FIN_ADD_B[i];
    end
    return s;
endfunction

`endif

// File: tb/tb_state_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_state_mixer;
    import mixer_types_pkg::*;
    import mixer_const_pkg::*;

    localparam int unsigned MIX_ROUNDS     = 2;
    localparam int unsigned CASCADE_ROUNDS = 4;
    localparam int  RUN_CYCLES    = 2400;
    localparam int  EDGE_TIMEOUT  = 40;  // ns without a rising edge.
    localparam int  RESET_TIMEOUT = 20;  // edges.
    localparam real DRIVE_DELAY   = 1.0;

    wire logic clk;
    wire logic reset;
    logic      step;
    logic      seed_load;
    lane_t     seed_value;
    state_t    state;

    logic [31:0] lfsr;
    state_t      shadow;
    int          edge_count = 0;
    real         last_edge = 0.0;
    int          steps_seen = 0;
    int          holds_seen = 0;
    int          loads_with_step = 0;

    `include "tb_mixer_model.svh"

    tb_clock_gen #(
        .PERIOD_NS    (8.0),
        .RESET_CYCLES (4)
    ) u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    state_mixer #(
        .MIX_ROUNDS     (MIX_ROUNDS),
        .CASCADE_ROUNDS (CASCADE_ROUNDS)
    ) dut (
        .clk        (clk),
        .reset      (reset),
        .step       (step),
        .seed_load  (seed_load),
        .seed_value (seed_value),
        .state      (state)
    );

    always @(posedge clk) begin
        edge_count++;
        last_edge = $realtime;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    // returns DRIVE_DELAY after the next rising edge.
    task automatic wait_edge();
        int start;
        int waited;

        start = edge_count;
        waited = 0;
        while (edge_count == start) begin
            assert (waited < EDGE_TIMEOUT)
                else fail_run("clock stopped, no rising edge within the timeout");
            #1;
            waited++;
        end
        #(last_edge + DRIVE_DELAY - $realtime);
    endtask

    task automatic check_state(input state_t expected);
        assert (state === expected) else begin
            fail_run($sformatf("mismatch at %0d ns: state expected %h, got %h",
                               $time, expected, state));
        end
    endtask

    // msb first, one LFSR step per bit.
    task automatic draw_bits(input int count, output logic [31:0] bits);
        bits = '0;
        for (int n = 0; n < count; n++) begin
            lfsr = lfsr_next(lfsr);
            bits = {bits[30:0], lfsr[0]};
        end
    endtask

    initial begin
        logic [31:0] bits;
        int          waited;

        step = 1'b0;
        seed_load = 1'b0;
        seed_value = '0;
        lfsr = 32'd49;

        waited = 0;
        wait_edge();
        while (reset !== 1'b0) begin
            assert (waited < RESET_TIMEOUT) else fail_run("reset was never released");
            wait_edge();
            waited++;
        end

        shadow = model_seed('0);  // index pattern.
        check_state(shadow);

        for (int cycle = 0; cycle < RUN_CYCLES; cycle++) begin
            draw_bits(1, bits);
            step = bits[0];
            draw_bits(4, bits);
            seed_load = (bits[3:0] == 4'd0);  // one in sixteen.
            draw_bits(32, bits);
            seed_value = bits;

            if (seed_load) begin
                shadow = model_seed(seed_value);
                if (step) begin
                    loads_with_step++;
                end
            end else if (step) begin
                shadow = model_update(shadow, MIX_ROUNDS, CASCADE_ROUNDS);
                steps_seen++;
            end else begin
                holds_seen++;
            end

            wait_edge();
            check_state(shadow);
        end

        assert (steps_seen > 0 && holds_seen > 0 && loads_with_step > 0)
            else fail_run("random run never hit a step, a hold and a seed load with step");

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+tb
src/mixer_types_pkg.sv
src/mixer_const_pkg.sv
src/lane_state.sv
src/mix_prelude.sv
src/mix_round.sv
src/cascade_round.sv
src/mix_finalize.sv
src/state_mixer.sv
tb/tb_clock_gen.sv
tb/tb_state_mixer.sv

// File: Bender.yml
package:
  name: state_mixer

sources:
  - src/mixer_types_pkg.sv
  - src/mixer_const_pkg.sv
  - src/lane_state.sv
  - src/mix_prelude.sv
  - src/mix_round.sv
  - src/cascade_round.sv
  - src/mix_finalize.sv
  - src/state_mixer.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_state_mixer.sv
